//--- verilog.f
design/fpadd_pkg.sv
design/fpadd_sequencer.sv
design/fpadd_align.sv
design/fpadd_shifter.sv
design/fpadd_sgf_norm.sv
design/fpadd_format.sv
design/fpadd_top.sv
sim/tb_fpadd.sv

//--- run_sim.sh
#!/bin/sh
# Build tb_fpadd with Verilator, run it, judge the run from sim.log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --top-module tb_fpadd -f verilog.f -o tb_fpadd_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_fpadd_sim > "$LOG" 2>&1
cat "$LOG"
grep -q "Testbench failed" "$LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" "$LOG" || { echo "No pass line in $LOG"; exit 1; }
echo "Simulation PASSED"

//--- sim/fpadd_testdata.txt
// Columns: x y op(0 add, 1 sub) expected_result overflow underflow zero
// First word is the number of vectors, all values hex
18
// Same-sign add, with and without carry, truncation, big gaps
3F800000 3F800000 0 40000000 0 0 0
3F800000 3F000000 0 3FC00000 0 0 0
3FC00000 3FE00000 0 40500000 0 0 0
3F800000 3F800001 0 40000000 0 0 0
3F800000 33800000 0 3F800000 0 0 0
3F800000 30800000 0 3F800000 0 0 0
3F800000 71800000 0 71800000 0 0 0
BFC00000 BFC00000 0 C0400000 0 0 0
C0000000 3F800000 1 C0400000 0 0 0
7F000000 7E800000 0 7F400000 0 0 0
// Effective subtract, cancellation and left normalize
3F800001 3F800000 1 34000000 0 0 0
3FC00000 3FC00001 1 B4000000 0 0 0
40400000 40200000 1 3F000000 0 0 0
3F800000 33800000 1 3F7FFFFF 0 0 0
3F800000 BF400000 0 3E800000 0 0 0
// Equal magnitudes cancel to +0
40490FDB 40490FDB 1 00000000 0 1 1
C1200000 41200000 0 00000000 0 1 1
// Overflow to signed infinity
7F7FFFFF 7F7FFFFF 0 7F800000 1 0 0
FF000000 FF000000 0 FF800000 1 0 0
7F000000 FF400000 1 7F800000 1 0 0
// Underflow below exponent 1, and the exponent 1 boundary
00800001 00800000 1 00000000 0 1 0
80800001 80800000 1 80000000 0 1 0
01000000 00800000 1 00800000 0 0 0
00C00000 00800000 1 00000000 0 1 0

//--- sim/tb_fpadd.sv
// FP adder testbench
// Clock and reset, vectors read from the testdata file,
// result and flag checks, start/busy/ready handshake check,
// cycle-count watchdog
module tb_fpadd import fpadd_pkg::*; ();

  // Words per vector: x, y, op, result, ovf, unf, zero
  localparam int FIELDS  = 7;
  localparam int MAX_VEC = 64;

  logic         clk;
  logic         rst;
  logic         start;
  logic         add_sub;
  word_t        x, y, result;
  logic         overflow, underflow, zero, busy, ready;
  // Word 0 is the vector count
  logic [31:0]  tv_mem [0:FIELDS*MAX_VEC];
  int           n_vec;
  int           cycle_count = 0;
  int           cycle_limit;

  fpadd_top fpadd_top_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .start_i     (start),
    .x_i         (x),
    .y_i         (y),
    .add_sub_i   (add_sub),
    .result_o    (result),
    .overflow_o  (overflow),
    .underflow_o (underflow),
    .zero_o      (zero),
    .busy_o      (busy),
    .ready_o     (ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
      stop_with_failure();
    end
  endtask

  // Start pulse for one cycle, returns after the sampling edge
  task automatic start_operation(input word_t a, input word_t b, input logic op);
    @(posedge clk);
    x       <= a;
    y       <= b;
    add_sub <= op;
    start   <= 1'b1;
    @(posedge clk);
    start   <= 1'b0;
  endtask

  task automatic wait_for_ready();
    @(negedge clk);
    while (ready !== 1'b1) @(negedge clk);
  endtask

  task automatic check_vector(input int v);
    int base;
    base = 1 + FIELDS * v;
    start_operation(tv_mem[base], tv_mem[base+1], tv_mem[base+2][0]);
    wait_for_ready();
    check_value($sformatf("result_o (vector %0d)", v), result, tv_mem[base+3]);
    check_value($sformatf("overflow_o (vector %0d)", v), 32'(overflow), tv_mem[base+4]);
    check_value($sformatf("underflow_o (vector %0d)", v), 32'(underflow), tv_mem[base+5]);
    check_value($sformatf("zero_o (vector %0d)", v), 32'(zero), tv_mem[base+6]);
  endtask

  // Vector 0 again, with vector 1 pulsed in while busy
  task automatic check_handshake();
    start_operation(tv_mem[1], tv_mem[2], tv_mem[3][0]);
    for (int i = 0; i < LATENCY; i++) begin
      @(negedge clk);
      check_value("ready_o before latency", 32'(ready), 32'd0);
      check_value("busy_o during run", 32'(busy), 32'd1);
      @(posedge clk);
      if (i == 2) begin
        x       <= tv_mem[8];
        y       <= tv_mem[9];
        add_sub <= tv_mem[10][0];
        start   <= 1'b1;
      end else begin
        start   <= 1'b0;
      end
    end
    @(negedge clk);
    check_value("ready_o at latency", 32'(ready), 32'd1);
    check_value("busy_o at ready", 32'(busy), 32'd0);
    check_value("result_o after busy start", result, tv_mem[4]);
    // Ignored start must leave no second result
    repeat (LATENCY + 2) begin
      @(negedge clk);
      check_value("ready_o after ignored start", 32'(ready), 32'd0);
      check_value("busy_o after ignored start", 32'(busy), 32'd0);
    end
    check_value("result_o held", result, tv_mem[4]);
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run still going after %0d cycles", cycle_count);
      stop_with_failure();
    end
  end

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    rst     = 1'b1;
    start   = 1'b0;
    add_sub = 1'b0;
    x       = '0;
    y       = '0;
    $readmemh("sim/fpadd_testdata.txt", tv_mem);
    n_vec = tv_mem[0];
    if (n_vec < 2 || n_vec > MAX_VEC) begin
      $display("Testdata file holds no usable vector count: %0d", n_vec);
      stop_with_failure();
    end
    cycle_limit = n_vec * (LATENCY + 4) + 50;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    // Outputs cleared by reset
    @(negedge clk);
    check_value("busy_o after reset", 32'(busy), 32'd0);
    check_value("ready_o after reset", 32'(ready), 32'd0);
    check_value("overflow_o after reset", 32'(overflow), 32'd0);
    check_value("underflow_o after reset", 32'(underflow), 32'd0);
    check_value("zero_o after reset", 32'(zero), 32'd0);
    check_value("result_o after reset", result, 32'd0);
    for (int v = 0; v < n_vec; v++) begin
      check_vector(v);
    end
    check_handshake();
    $display("%0d vectors and the handshake checked", n_vec);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- design/fpadd_top.sv
// FP adder/subtractor top
// Sequencer, align, shared shifter, significand
// adder and formatter wired together
module fpadd_top import fpadd_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   start_i,
  input  word_t  x_i,
  input  word_t  y_i,
  input  logic   add_sub_i,
  output word_t  result_o,
  output logic   overflow_o,
  output logic   underflow_o,
  output logic   zero_o,
  output logic   busy_o,
  output logic   ready_o
);

  logic [ST_NRM2:0]  tokens;
  logic              load_in;
  mag_t              dmp;
  sgf_t              small_sgf;
  shamt_t            align_shamt;
  op_e               eff_op;
  logic              res_sign, res_zero;
  sgf_t              shift_data;
  sgf_t              raw_sum;
  logic              sum_carry;
  shamt_t            lzd_count;
  exp_t              dmp_exp;

  fpadd_sequencer u_seq (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (start_i),
    .tokens_o  (tokens),
    .load_in_o (load_in),
    .busy_o    (busy_o)
  );

  fpadd_align u_align (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .load_in_i  (load_in),
    .tok_init_i (tokens[ST_INIT]),
    .tok_exp_i  (tokens[ST_EXP]),
    .x_i        (x_i),
    .y_i        (y_i),
    .add_sub_i  (add_sub_i),
    .dmp_o      (dmp),
    .dmp_sgf_o  (small_sgf),
    .shamt_o    (align_shamt),
    .op_o       (eff_op),
    .sign_o     (res_sign),
    .zero_o     (res_zero)
  );

  // One shifter, align pass then normalize pass
  fpadd_shifter u_shift (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .tok_sht1_i    (tokens[ST_SHT1]),
    .tok_nrm_i     (tokens[ST_NRM]),
    .align_data_i  (small_sgf),
    .align_shamt_i (align_shamt),
    .norm_data_i   (raw_sum),
    .lzd_count_i   (lzd_count),
    .carry_i       (sum_carry),
    .data_o        (shift_data)
  );

  fpadd_sgf_norm u_sgf (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .tok_sgf_i   (tokens[ST_SGF]),
    .dmp_i       (dmp),
    .dmp_sgf_i   (shift_data),
    .op_i        (eff_op),
    .raw_o       (raw_sum),
    .carry_o     (sum_carry),
    .lzd_count_o (lzd_count),
    .exp_o       (dmp_exp)
  );

  fpadd_format u_fmt (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .tok_nrm_i   (tokens[ST_NRM]),
    .tok_nrm2_i  (tokens[ST_NRM2]),
    .exp_i       (dmp_exp),
    .lzd_count_i (lzd_count),
    .carry_i     (sum_carry),
    .sign_i      (res_sign),
    .zero_i      (res_zero),
    .sgf_i       (shift_data),
    .result_o    (result_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .zero_o      (zero_o),
    .ready_o     (ready_o)
  );

endmodule

//--- design/fpadd_format.sv
// Result formatting
// Exponent adjust, overflow/underflow detect,
// IEEE packing, output and ready registers
module fpadd_format import fpadd_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    tok_nrm_i,
  input  logic    tok_nrm2_i,
  input  exp_t    exp_i,
  input  shamt_t  lzd_count_i,
  input  logic    carry_i,
  input  logic    sign_i,
  input  logic    zero_i,
  input  sgf_t    sgf_i,
  output word_t   result_o,
  output logic    overflow_o,
  output logic    underflow_o,
  output logic    zero_o,
  output logic    ready_o
);

  exp_t      exp_q;
  shamt_t    cnt_q;
  logic      carry_q, sign_q, zero_q;
  exp_ext_t  exp_adj;
  logic      ovf_c, unf_c;
  word_t     packed_c;

  always_ff @(posedge clk_i) begin
    if (tok_nrm_i) begin
      exp_q <= exp_i;
      cnt_q <= lzd_count_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      carry_q <= 1'b0;
      sign_q  <= 1'b0;
      zero_q  <= 1'b0;
    end else if (tok_nrm_i) begin
      carry_q <= carry_i;
      sign_q  <= sign_i;
      zero_q  <= zero_i;
    end
  end

  // Carry bumps by one, else drop by leading zeros
  always_comb begin
    if (carry_q) begin
      exp_adj = exp_ext_t'({1'b0, exp_q}) + exp_ext_t'(1);
    end else begin
      exp_adj = exp_ext_t'({1'b0, exp_q}) - exp_ext_t'({{(EW-EWR+1){1'b0}}, cnt_q});
    end
  end

  assign ovf_c = exp_adj >= exp_ext_t'(EXP_MAX);
  assign unf_c = (exp_adj <= exp_ext_t'(0)) || zero_q;

  always_comb begin
    if (ovf_c) begin
      packed_c = {sign_q, {EW{1'b1}}, {SW{1'b0}}};
    end else if (unf_c) begin
      // Exact cancellation is always +0
      packed_c = {sign_q && !zero_q, {(W-1){1'b0}}};
    end else begin
      packed_c = {sign_q, exp_adj[EW-1:0], sgf_i[SWR-2:2]};
    end
  end

  // ================================================
  // Output registers
  // ================================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_o    <= '0;
      overflow_o  <= 1'b0;
      underflow_o <= 1'b0;
      zero_o      <= 1'b0;
      ready_o     <= 1'b0;
    end else begin
      ready_o <= tok_nrm2_i;
      if (tok_nrm2_i) begin
        result_o    <= packed_c;
        overflow_o  <= ovf_c;
        underflow_o <= unf_c;
        zero_o      <= zero_q;
      end
    end
  end

endmodule

//--- design/fpadd_sgf_norm.sv
// Significand add/subtract stage
// Larger significand rebuild, add or subtract,
// carry detect, exponent hold, leading-zero count
module fpadd_sgf_norm import fpadd_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    tok_sgf_i,
  input  mag_t    dmp_i,
  input  sgf_t    dmp_sgf_i,
  input  op_e     op_i,
  output sgf_t    raw_o,
  output logic    carry_o,
  output shamt_t  lzd_count_o,
  output exp_t    exp_o
);

  sgf_t            big_sgf;
  logic [SWR:0]    sum_c;
  sgf_t            raw_q;
  logic            carry_q;
  exp_t            exp_q;
  shamt_t          lzd_c;

  // Hidden bit and guard bits around stored fraction
  assign big_sgf = {1'b1, dmp_i[SW-1:0], 2'b00};

  // Larger minus smaller never borrows
  always_comb begin
    if (op_i == OP_ADD) begin
      sum_c = {1'b0, big_sgf} + {1'b0, dmp_sgf_i};
    end else begin
      sum_c = {1'b0, big_sgf} - {1'b0, dmp_sgf_i};
    end
  end

  // ================================================
  // SGF stage registers
  // ================================================
  always_ff @(posedge clk_i) begin
    if (tok_sgf_i) begin
      raw_q <= sum_c[SWR-1:0];
      exp_q <= dmp_i[W-2:SW];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      carry_q <= 1'b0;
    end else if (tok_sgf_i) begin
      // Carry out only counts for a true add
      carry_q <= sum_c[SWR] && (op_i == OP_ADD);
    end
  end

  // Leading zeros, highest set bit wins
  // All-zero sum gives SWR
  always_comb begin
    lzd_c = shamt_t'(SWR);
    for (int i = 0; i < SWR; i++) begin
      if (raw_q[i]) lzd_c = shamt_t'(SWR - 1 - i);
    end
  end

  assign raw_o       = raw_q;
  assign carry_o     = carry_q;
  assign lzd_count_o = lzd_c;
  assign exp_o       = exp_q;

endmodule

//--- design/fpadd_shifter.sv
// Shared two-half barrel shifter
// Pass select for align and normalize, bit reversal
// for left shifts, levels 0-1 before and 2-4 after mid register
module fpadd_shifter import fpadd_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    tok_sht1_i,
  input  logic    tok_nrm_i,
  input  sgf_t    align_data_i,
  input  shamt_t  align_shamt_i,
  input  sgf_t    norm_data_i,
  input  shamt_t  lzd_count_i,
  input  logic    carry_i,
  output sgf_t    data_o
);

  sgf_t              data_sel, half1, half2;
  shamt_t            shamt_sel;
  logic              left_sel, bit_sel;
  sgf_t              mid_data_q;
  logic [EWR-1:2]    mid_shamt_q;
  logic              mid_left_q, mid_bit_q;

  function automatic sgf_t bit_rev(input sgf_t d);
    sgf_t r;
    for (int i = 0; i < SWR; i++) begin
      r[i] = d[SWR-1-i];
    end
    return r;
  endfunction

  // Right shift by n, fill from the top with b
  function automatic sgf_t shr_fill(input sgf_t d, input int n, input logic b);
    sgf_t fill;
    fill = ~(sgf_t'('1) >> n);
    return (d >> n) | (b ? fill : '0);
  endfunction

  // ================================================
  // Pass select and first half
  // ================================================
  always_comb begin
    data_sel  = tok_nrm_i ? norm_data_i : align_data_i;
    // Carry: one right with the carry as new hidden bit
    shamt_sel = tok_nrm_i ? (carry_i ? shamt_t'(1) : lzd_count_i) : align_shamt_i;
    left_sel  = tok_nrm_i && !carry_i;
    bit_sel   = tok_nrm_i && carry_i;
    half1     = left_sel ? bit_rev(data_sel) : data_sel;
    for (int k = 0; k < 2; k++) begin
      if (shamt_sel[k]) half1 = shr_fill(half1, 1 << k, bit_sel);
    end
  end

  always_ff @(posedge clk_i) begin
    if (tok_sht1_i || tok_nrm_i) mid_data_q <= half1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mid_shamt_q <= '0;
      mid_left_q  <= 1'b0;
      mid_bit_q   <= 1'b0;
    end else if (tok_sht1_i || tok_nrm_i) begin
      mid_shamt_q <= shamt_sel[EWR-1:2];
      mid_left_q  <= left_sel;
      mid_bit_q   <= bit_sel;
    end
  end

  // Upper three levels, undo reversal
  always_comb begin
    half2 = mid_data_q;
    for (int k = 2; k < EWR; k++) begin
      if (mid_shamt_q[k]) half2 = shr_fill(half2, 1 << k, mid_bit_q);
    end
  end

  assign data_o = mid_left_q ? bit_rev(half2) : half2;

endmodule

//--- design/fpadd_align.sv
// Operand alignment front end
// Input capture, magnitude compare and swap,
// effective operation, result sign, zero detect,
// saturated exponent difference
module fpadd_align import fpadd_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    load_in_i,
  input  logic    tok_init_i,
  input  logic    tok_exp_i,
  input  word_t   x_i,
  input  word_t   y_i,
  input  logic    add_sub_i,
  output mag_t    dmp_o,
  output sgf_t    dmp_sgf_o,
  output shamt_t  shamt_o,
  output op_e     op_o,
  output logic    sign_o,
  output logic    zero_o
);

  word_t   x_q, y_q;
  logic    as_q;
  logic    gt_xy, eq_xy;
  logic    eff_sub;
  mag_t    dmp_q, dmin_q;
  exp_t    exp_diff;
  shamt_t  shamt_q;
  op_e     op_q;
  logic    sign_q, zero_q;

  // Operand capture on the accepting edge
  always_ff @(posedge clk_i) begin
    if (load_in_i) begin
      x_q  <= x_i;
      y_q  <= y_i;
      as_q <= add_sub_i;
    end
  end

  // Magnitude compare, sign bits excluded
  assign gt_xy   = x_q[W-2:0] > y_q[W-2:0];
  assign eq_xy   = x_q[W-2:0] == y_q[W-2:0];
  // Unlike signs flip the requested operation
  assign eff_sub = x_q[W-1] ^ y_q[W-1] ^ as_q;

  // ================================================
  // INIT stage: swap and flags
  // ================================================
  always_ff @(posedge clk_i) begin
    if (tok_init_i) begin
      dmp_q  <= gt_xy ? x_q[W-2:0] : y_q[W-2:0];
      dmin_q <= gt_xy ? y_q[W-2:0] : x_q[W-2:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      op_q   <= OP_ADD;
      sign_q <= 1'b0;
      zero_q <= 1'b0;
    end else if (tok_init_i) begin
      op_q   <= eff_sub ? OP_SUB : OP_ADD;
      // y contributes its sign flipped by a subtract
      sign_q <= gt_xy ? x_q[W-1] : (y_q[W-1] ^ as_q);
      zero_q <= eff_sub && eq_xy;
    end
  end

  // ================================================
  // EXP stage: shift amount
  // ================================================
  assign exp_diff = dmp_q[W-2:SW] - dmin_q[W-2:SW];

  always_ff @(posedge clk_i) begin
    if (tok_exp_i) begin
      // Gaps past 31 flush the small operand entirely
      shamt_q <= (exp_diff > exp_t'(31)) ? '1 : exp_diff[EWR-1:0];
    end
  end

  assign dmp_o     = dmp_q;
  assign dmp_sgf_o = {1'b1, dmin_q[SW-1:0], 2'b00};
  assign shamt_o   = shamt_q;
  assign op_o      = op_q;
  assign sign_o    = sign_q;
  assign zero_o    = zero_q;

endmodule

//--- design/fpadd_sequencer.sv
// Stage sequencer for the FP adder
// Idle/run FSM, input load strobe, launch delay
// and the one-hot stage-token shift register
module fpadd_sequencer import fpadd_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              start_i,
  output logic [ST_NRM2:0]  tokens_o,
  output logic              load_in_o,
  output logic              busy_o
);

  seq_state_e             state_q;
  logic [1:0]             launch_q;
  logic [ST_NRM2:0]       tokens_q;

  // Accept start only when idle
  assign load_in_o = start_i && (state_q == SEQ_IDLE);
  assign busy_o    = (state_q == SEQ_RUN);
  assign tokens_o  = tokens_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= SEQ_IDLE;
    end else begin
      case (state_q)
        SEQ_IDLE: if (load_in_o) state_q <= SEQ_RUN;
        // Back to idle as the last token drops out
        SEQ_RUN:  if (tokens_q[ST_NRM2]) state_q <= SEQ_IDLE;
        default:  state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Two-edge launch delay, then one token walks the chain
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      launch_q <= '0;
      tokens_q <= '0;
    end else begin
      launch_q <= {launch_q[0], load_in_o};
      tokens_q <= {tokens_q[ST_NRM:ST_INIT], launch_q[1]};
    end
  end

endmodule

//--- design/fpadd_pkg.sv
// Single-precision FP adder package
// Format widths, working types, effective-operation,
// sequencer state and stage-token enums
package fpadd_pkg;

  // ================================================
  // Format constants
  // ================================================
  localparam int W       = 32;
  localparam int EW      = 8;
  localparam int SW      = 23;
  // Hidden bit, fraction, two guard bits
  localparam int SWR     = 26;
  localparam int EWR     = 5;
  localparam int EXP_MAX = 255;
  // Start edge to ready edge
  localparam int LATENCY = 9;

  // ================================================
  // Working types
  // ================================================
  typedef logic [W-1:0]         word_t;
  typedef logic [W-2:0]         mag_t;
  typedef logic [EW-1:0]        exp_t;
  typedef logic signed [EW:0]   exp_ext_t;
  typedef logic [SWR-1:0]       sgf_t;
  typedef logic [EWR-1:0]       shamt_t;

  // Effective operation after sign folding
  typedef enum logic {OP_ADD = 1'b0, OP_SUB = 1'b1} op_e;

  typedef enum logic {SEQ_IDLE = 1'b0, SEQ_RUN = 1'b1} seq_state_e;

  // Token bit positions, INIT enters first
  typedef enum logic [2:0] {
    ST_INIT = 3'd0,
    ST_EXP  = 3'd1,
    ST_SHT1 = 3'd2,
    ST_SHT2 = 3'd3,
    ST_SGF  = 3'd4,
    ST_NRM  = 3'd5,
    ST_NRM2 = 3'd6
  } stage_e;

endpackage
